//--- logic/delay_pkg.sv
package delay_pkg;

	// Samples and channels.
	localparam int DATA_WIDTH   = 16;
	localparam int N_CHANNELS   = 4;
	localparam int HANDLE_WIDTH = 2;

	// Shared sample memory.
	localparam int MEM_DEPTH  = 256;
	localparam int ADDR_WIDTH = 8;

	// Delay in samples times 256, unsigned.
	localparam int DELAY_FRAC  = 8;
	localparam int DELAY_WIDTH = 24;

	// Gain is unsigned Q2.14, unity at 16384.
	localparam int GAIN_WIDTH = 16;
	localparam logic [GAIN_WIDTH-1:0] GAIN_STEP = 16'd64;
	localparam logic [GAIN_WIDTH-1:0] GAIN_MAX  = 16'd16384;
	localparam int GAIN_SHIFT = 14;

endpackage

//--- logic/delay_channel.sv
module delay_channel (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic init,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] init_addr,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] init_size,
	input  logic [delay_pkg::DELAY_WIDTH-1:0] init_delay,
	input  logic write,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] data_in,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] delay_inc,
	output logic signed [delay_pkg::DATA_WIDTH-1:0] data_out,
	output logic data_out_valid,
	output logic [delay_pkg::GAIN_WIDTH-1:0] gain,
	output logic ready,
	output logic write_done,
	output logic mem_read_req,
	output logic mem_write_req,
	output logic [delay_pkg::ADDR_WIDTH-1:0] mem_read_addr,
	output logic [delay_pkg::ADDR_WIDTH-1:0] mem_write_addr,
	output logic signed [delay_pkg::DATA_WIDTH-1:0] mem_data_out,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] mem_data_in,
	input  logic mem_read_valid,
	input  logic mem_write_ack
);

	typedef enum logic [1:0] {
		IDLE,
		WRITE_WAIT,
		READ_WAIT
	} state_t;

	state_t state;

	logic [delay_pkg::ADDR_WIDTH-1:0] base;
	logic [delay_pkg::ADDR_WIDTH-1:0] size;
	logic [delay_pkg::ADDR_WIDTH-1:0] position;
	logic [delay_pkg::DELAY_WIDTH-1:0] delay;
	logic wrapped;

	logic [delay_pkg::DELAY_WIDTH-1:0] max_delay;
	logic [delay_pkg::DELAY_WIDTH-1:0] init_max;
	logic [delay_pkg::DELAY_WIDTH-delay_pkg::DELAY_FRAC-1:0] delay_int;
	logic [delay_pkg::ADDR_WIDTH-1:0] tap_offset;
	logic signed [delay_pkg::DELAY_WIDTH:0] inc_ext;
	logic signed [delay_pkg::DELAY_WIDTH:0] max_inc;
	logic signed [delay_pkg::DELAY_WIDTH:0] min_inc;
	logic signed [delay_pkg::DELAY_WIDTH:0] inc_clamped;

	assign ready = (state == IDLE);

	assign max_delay = delay_pkg::DELAY_WIDTH'(size) << delay_pkg::DELAY_FRAC;
	assign init_max  = delay_pkg::DELAY_WIDTH'(init_size) << delay_pkg::DELAY_FRAC;

	// Tap lies delay_int slots behind the write position, wrapped in the region.
	assign delay_int  = delay[delay_pkg::DELAY_WIDTH-1:delay_pkg::DELAY_FRAC];
	assign tap_offset = (delay_int > position)
		? delay_pkg::ADDR_WIDTH'(position + size - delay_int)
		: delay_pkg::ADDR_WIDTH'(position - delay_int);

	// Increment limits keep the delay within 0 .. size * 256.
	assign inc_ext = (delay_pkg::DELAY_WIDTH+1)'(delay_inc);
	assign max_inc = $signed({1'b0, max_delay}) - $signed({1'b0, delay});
	assign min_inc = -$signed({1'b0, delay});

	always_ff @(posedge clk) begin
		if (reset) begin
			state          <= IDLE;
			wrapped        <= 1'b0;
			data_out_valid <= 1'b0;
			write_done     <= 1'b0;
			mem_read_req   <= 1'b0;
			mem_write_req  <= 1'b0;
		end else if (enable) begin
			write_done <= 1'b0;
			if (init) begin
				state          <= IDLE;
				base           <= init_addr;
				size           <= init_size;
				delay          <= (init_delay > init_max) ? init_max : init_delay;
				position       <= '0;
				wrapped        <= 1'b0;
				gain           <= '0;
				data_out       <= '0;
				data_out_valid <= 1'b1;
				mem_read_req   <= 1'b0;
				mem_write_req  <= 1'b0;
			end else begin
				case (state)
					IDLE: begin
						if (write) begin
							data_out_valid <= 1'b0;
							mem_write_addr <= base + position;
							mem_data_out   <= data_in;
							mem_write_req  <= 1'b1;
							if (inc_ext > max_inc) begin
								inc_clamped <= max_inc;
							end else if (inc_ext < min_inc) begin
								inc_clamped <= min_inc;
							end else begin
								inc_clamped <= inc_ext;
							end
							state <= WRITE_WAIT;
						end
					end
					WRITE_WAIT: begin
						if (mem_write_ack) begin
							mem_write_req <= 1'b0;
							mem_read_addr <= base + tap_offset;
							mem_read_req  <= 1'b1;
							delay <= delay_pkg::DELAY_WIDTH'($signed({1'b0, delay}) + inc_clamped);
							state <= READ_WAIT;
						end
					end
					READ_WAIT: begin
						if (mem_read_valid) begin
							data_out       <= mem_data_in;
							data_out_valid <= 1'b1;
							mem_read_req   <= 1'b0;
							write_done     <= 1'b1;
							state          <= IDLE;
							if (position == size - 1'b1) begin
								position <= '0;
								wrapped  <= 1'b1;
							end else begin
								position <= position + 1'b1;
							end
							// Fade in only once the region holds real history.
							if (wrapped && gain < delay_pkg::GAIN_MAX)
								gain <= gain + delay_pkg::GAIN_STEP;
						end
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

endmodule

//--- logic/command_dispatch.sv
module command_dispatch (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic alloc_req,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] alloc_size,
	input  logic [delay_pkg::DELAY_WIDTH-1:0] alloc_delay,
	input  logic write_req,
	input  logic [delay_pkg::HANDLE_WIDTH-1:0] write_handle,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] write_data,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] write_inc,
	output logic write_ack,
	output logic write_done,
	output logic invalid_alloc,
	output logic invalid_write,
	output logic [delay_pkg::N_CHANNELS-1:0] chan_init,
	output logic [delay_pkg::N_CHANNELS-1:0] chan_write,
	output logic [delay_pkg::ADDR_WIDTH-1:0] init_addr,
	output logic [delay_pkg::ADDR_WIDTH-1:0] init_size,
	output logic [delay_pkg::DELAY_WIDTH-1:0] init_delay,
	output logic signed [delay_pkg::DATA_WIDTH-1:0] data_in,
	output logic signed [delay_pkg::DATA_WIDTH-1:0] delay_inc,
	input  logic [delay_pkg::N_CHANNELS-1:0] chan_ready,
	input  logic [delay_pkg::N_CHANNELS-1:0] chan_write_done,
	input  logic [delay_pkg::N_CHANNELS-1:0] chan_mem_read_req,
	input  logic [delay_pkg::N_CHANNELS-1:0] chan_mem_write_req,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] chan_mem_read_addr [delay_pkg::N_CHANNELS],
	input  logic [delay_pkg::ADDR_WIDTH-1:0] chan_mem_write_addr [delay_pkg::N_CHANNELS],
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] chan_mem_data_out [delay_pkg::N_CHANNELS],
	output logic mem_write_en,
	output logic [delay_pkg::ADDR_WIDTH-1:0] mem_write_addr,
	output logic [delay_pkg::DATA_WIDTH-1:0] mem_write_data,
	output logic mem_read_req,
	output logic [delay_pkg::ADDR_WIDTH-1:0] mem_read_addr,
	output logic [delay_pkg::HANDLE_WIDTH:0] alloc_count
);

	logic [delay_pkg::ADDR_WIDTH:0] alloc_base;
	logic [delay_pkg::ADDR_WIDTH:0] alloc_end;
	logic alloc_ok;
	logic write_ok;

	logic writing;
	logic dispatched;
	logic [delay_pkg::HANDLE_WIDTH-1:0] handle_q;

	logic fwd_write;
	logic fwd_read;
	logic fwd_write_d;
	logic fwd_read_d;

	assign alloc_end = alloc_base + {1'b0, alloc_size};
	assign alloc_ok  = (alloc_count < delay_pkg::N_CHANNELS) && (alloc_size != '0)
		&& (alloc_end <= delay_pkg::MEM_DEPTH);
	assign write_ok  = ({1'b0, write_handle} < alloc_count);

	assign fwd_write  = dispatched && chan_mem_write_req[handle_q];
	assign fwd_read   = dispatched && chan_mem_read_req[handle_q];
	assign write_done = dispatched && chan_write_done[handle_q];

	always_ff @(posedge clk) begin
		if (reset) begin
			alloc_count   <= '0;
			alloc_base    <= '0;
			chan_init     <= '0;
			chan_write    <= '0;
			write_ack     <= 1'b0;
			invalid_alloc <= 1'b0;
			invalid_write <= 1'b0;
			writing       <= 1'b0;
			dispatched    <= 1'b0;
			fwd_write_d   <= 1'b0;
			fwd_read_d    <= 1'b0;
			mem_write_en  <= 1'b0;
			mem_read_req  <= 1'b0;
		end else if (enable) begin
			chan_init     <= '0;
			chan_write    <= '0;
			write_ack     <= 1'b0;
			invalid_alloc <= 1'b0;
			invalid_write <= 1'b0;

			if (alloc_req) begin
				if (alloc_ok) begin
					chan_init[alloc_count[delay_pkg::HANDLE_WIDTH-1:0]] <= 1'b1;
					init_addr   <= alloc_base[delay_pkg::ADDR_WIDTH-1:0];
					init_size   <= alloc_size;
					init_delay  <= alloc_delay;
					alloc_base  <= alloc_end;
					alloc_count <= alloc_count + 1'b1;
				end else begin
					invalid_alloc <= 1'b1;
				end
			end

			// One write at a time. A held request waits here for back-pressure.
			if (!writing) begin
				if (write_req) begin
					if (write_ok) begin
						write_ack <= 1'b1;
						writing   <= 1'b1;
						handle_q  <= write_handle;
						data_in   <= write_data;
						delay_inc <= write_inc;
						if (chan_ready[write_handle]) begin
							chan_write[write_handle] <= 1'b1;
							dispatched <= 1'b1;
						end
					end else begin
						invalid_write <= 1'b1;
					end
				end
			end else if (!dispatched) begin
				if (chan_ready[handle_q]) begin
					chan_write[handle_q] <= 1'b1;
					dispatched <= 1'b1;
				end
			end else if (chan_write_done[handle_q]) begin
				writing    <= 1'b0;
				dispatched <= 1'b0;
			end

			// Channel requests stay high until answered, so pass on the rising edge only.
			fwd_write_d  <= fwd_write;
			fwd_read_d   <= fwd_read;
			mem_write_en <= fwd_write && !fwd_write_d;
			mem_read_req <= fwd_read && !fwd_read_d;
		end
	end

	always_ff @(posedge clk) begin
		if (enable) begin
			mem_write_addr <= chan_mem_write_addr[handle_q];
			mem_write_data <= chan_mem_data_out[handle_q];
			mem_read_addr  <= chan_mem_read_addr[handle_q];
		end
	end

endmodule

//--- logic/sample_memory.sv
module sample_memory (
	input  logic clk,
	input  logic write_en,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] write_addr,
	input  logic [delay_pkg::DATA_WIDTH-1:0] write_data,
	input  logic read_req,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] read_addr,
	output logic [delay_pkg::DATA_WIDTH-1:0] read_data,
	output logic read_valid,
	output logic write_ack
);

	logic [delay_pkg::DATA_WIDTH-1:0] mem [delay_pkg::MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (write_en)
			mem[write_addr] <= write_data;
		if (read_req)
			read_data <= mem[read_addr];
	end

	// Responses one cycle after the request.
	always_ff @(posedge clk) begin
		read_valid <= read_req;
		write_ack  <= write_en;
	end

endmodule

//--- logic/gain_output.sv
module gain_output (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic read_req,
	input  logic [delay_pkg::HANDLE_WIDTH-1:0] read_handle,
	input  logic [delay_pkg::HANDLE_WIDTH:0] alloc_count,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] chan_data [delay_pkg::N_CHANNELS],
	input  logic [delay_pkg::N_CHANNELS-1:0] chan_data_valid,
	input  logic [delay_pkg::GAIN_WIDTH-1:0] chan_gain [delay_pkg::N_CHANNELS],
	output logic signed [delay_pkg::DATA_WIDTH-1:0] read_data,
	output logic read_valid,
	output logic invalid_read
);

	logic pending;
	logic captured;
	logic [delay_pkg::HANDLE_WIDTH-1:0] handle_q;
	logic [delay_pkg::HANDLE_WIDTH-1:0] sel;

	logic signed [delay_pkg::DATA_WIDTH-1:0] sample;
	logic [delay_pkg::GAIN_WIDTH-1:0] sample_gain;
	logic signed [delay_pkg::DATA_WIDTH+delay_pkg::GAIN_WIDTH:0] product;

	assign sel     = pending ? handle_q : read_handle;
	assign product = sample * $signed({1'b0, sample_gain});

	always_ff @(posedge clk) begin
		if (reset) begin
			pending      <= 1'b0;
			captured     <= 1'b0;
			read_valid   <= 1'b0;
			invalid_read <= 1'b0;
		end else if (enable) begin
			read_valid   <= 1'b0;
			invalid_read <= 1'b0;
			if (captured) begin
				read_data  <= delay_pkg::DATA_WIDTH'(product >>> delay_pkg::GAIN_SHIFT);
				read_valid <= 1'b1;
				captured   <= 1'b0;
				pending    <= 1'b0;
			end else if (pending || read_req) begin
				if (!pending && ({1'b0, read_handle} >= alloc_count)) begin
					invalid_read <= 1'b1;
				end else begin
					pending  <= 1'b1;
					handle_q <= sel;
					// Wait out a write in progress on this channel.
					if (chan_data_valid[sel]) begin
						sample      <= chan_data[sel];
						sample_gain <= chan_gain[sel];
						captured    <= 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- logic/delay_engine.sv
module delay_engine (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  logic alloc_req,
	input  logic [delay_pkg::ADDR_WIDTH-1:0] alloc_size,
	input  logic [delay_pkg::DELAY_WIDTH-1:0] alloc_delay,
	output logic invalid_alloc,
	input  logic write_req,
	input  logic [delay_pkg::HANDLE_WIDTH-1:0] write_handle,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] write_data,
	input  logic signed [delay_pkg::DATA_WIDTH-1:0] write_inc,
	output logic write_ack,
	output logic write_done,
	output logic invalid_write,
	input  logic read_req,
	input  logic [delay_pkg::HANDLE_WIDTH-1:0] read_handle,
	output logic signed [delay_pkg::DATA_WIDTH-1:0] read_data,
	output logic read_valid,
	output logic invalid_read
);

	logic [delay_pkg::N_CHANNELS-1:0] chan_init;
	logic [delay_pkg::N_CHANNELS-1:0] chan_write;
	logic [delay_pkg::N_CHANNELS-1:0] chan_ready;
	logic [delay_pkg::N_CHANNELS-1:0] chan_write_done;
	logic [delay_pkg::N_CHANNELS-1:0] chan_data_valid;
	logic [delay_pkg::N_CHANNELS-1:0] chan_mem_read_req;
	logic [delay_pkg::N_CHANNELS-1:0] chan_mem_write_req;
	logic [delay_pkg::ADDR_WIDTH-1:0] chan_mem_read_addr [delay_pkg::N_CHANNELS];
	logic [delay_pkg::ADDR_WIDTH-1:0] chan_mem_write_addr [delay_pkg::N_CHANNELS];
	logic signed [delay_pkg::DATA_WIDTH-1:0] chan_mem_data_out [delay_pkg::N_CHANNELS];
	logic signed [delay_pkg::DATA_WIDTH-1:0] chan_data [delay_pkg::N_CHANNELS];
	logic [delay_pkg::GAIN_WIDTH-1:0] chan_gain [delay_pkg::N_CHANNELS];

	logic [delay_pkg::ADDR_WIDTH-1:0] init_addr;
	logic [delay_pkg::ADDR_WIDTH-1:0] init_size;
	logic [delay_pkg::DELAY_WIDTH-1:0] init_delay;
	logic signed [delay_pkg::DATA_WIDTH-1:0] data_in;
	logic signed [delay_pkg::DATA_WIDTH-1:0] delay_inc;
	logic [delay_pkg::HANDLE_WIDTH:0] alloc_count;

	logic mem_write_en;
	logic [delay_pkg::ADDR_WIDTH-1:0] mem_write_addr;
	logic [delay_pkg::DATA_WIDTH-1:0] mem_write_data;
	logic mem_read_req;
	logic [delay_pkg::ADDR_WIDTH-1:0] mem_read_addr;
	logic [delay_pkg::DATA_WIDTH-1:0] mem_read_data;
	logic mem_read_valid;
	logic mem_write_ack;

	command_dispatch i_dispatch (
		.clk                 (clk),
		.reset               (reset),
		.enable              (enable),
		.alloc_req           (alloc_req),
		.alloc_size          (alloc_size),
		.alloc_delay         (alloc_delay),
		.write_req           (write_req),
		.write_handle        (write_handle),
		.write_data          (write_data),
		.write_inc           (write_inc),
		.write_ack           (write_ack),
		.write_done          (write_done),
		.invalid_alloc       (invalid_alloc),
		.invalid_write       (invalid_write),
		.chan_init           (chan_init),
		.chan_write          (chan_write),
		.init_addr           (init_addr),
		.init_size           (init_size),
		.init_delay          (init_delay),
		.data_in             (data_in),
		.delay_inc           (delay_inc),
		.chan_ready          (chan_ready),
		.chan_write_done     (chan_write_done),
		.chan_mem_read_req   (chan_mem_read_req),
		.chan_mem_write_req  (chan_mem_write_req),
		.chan_mem_read_addr  (chan_mem_read_addr),
		.chan_mem_write_addr (chan_mem_write_addr),
		.chan_mem_data_out   (chan_mem_data_out),
		.mem_write_en        (mem_write_en),
		.mem_write_addr      (mem_write_addr),
		.mem_write_data      (mem_write_data),
		.mem_read_req        (mem_read_req),
		.mem_read_addr       (mem_read_addr),
		.alloc_count         (alloc_count)
	);

	sample_memory i_memory (
		.clk        (clk),
		.write_en   (mem_write_en),
		.write_addr (mem_write_addr),
		.write_data (mem_write_data),
		.read_req   (mem_read_req),
		.read_addr  (mem_read_addr),
		.read_data  (mem_read_data),
		.read_valid (mem_read_valid),
		.write_ack  (mem_write_ack)
	);

	gain_output i_output (
		.clk             (clk),
		.reset           (reset),
		.enable          (enable),
		.read_req        (read_req),
		.read_handle     (read_handle),
		.alloc_count     (alloc_count),
		.chan_data       (chan_data),
		.chan_data_valid (chan_data_valid),
		.chan_gain       (chan_gain),
		.read_data       (read_data),
		.read_valid      (read_valid),
		.invalid_read    (invalid_read)
	);

	// Memory responses go to every channel; only the busy one reacts.
	for (genvar i = 0; i < delay_pkg::N_CHANNELS; i++) begin : g_channel
		delay_channel i_channel (
			.clk            (clk),
			.reset          (reset),
			.enable         (enable),
			.init           (chan_init[i]),
			.init_addr      (init_addr),
			.init_size      (init_size),
			.init_delay     (init_delay),
			.write          (chan_write[i]),
			.data_in        (data_in),
			.delay_inc      (delay_inc),
			.data_out       (chan_data[i]),
			.data_out_valid (chan_data_valid[i]),
			.gain           (chan_gain[i]),
			.ready          (chan_ready[i]),
			.write_done     (chan_write_done[i]),
			.mem_read_req   (chan_mem_read_req[i]),
			.mem_write_req  (chan_mem_write_req[i]),
			.mem_read_addr  (chan_mem_read_addr[i]),
			.mem_write_addr (chan_mem_write_addr[i]),
			.mem_data_out   (chan_mem_data_out[i]),
			.mem_data_in    (mem_read_data),
			.mem_read_valid (mem_read_valid),
			.mem_write_ack  (mem_write_ack)
		);
	end

endmodule

//--- testbench/tb_delay_engine.sv
module tb_delay_engine;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int OP_ALLOC   = 0;
	localparam int OP_WRITE   = 1;
	localparam int OP_READ    = 2;
	localparam int OP_PAIR    = 3;
	localparam int WAIT_LIMIT = 30;

	// One table row per operation. value is a size or a sample, delta a delay or increment.
	typedef struct packed {
		int op;
		int handle;
		int value;
		int delta;
		bit rnd;
		bit bad;
	} row_t;

	logic clk;
	logic reset;
	logic enable;
	logic alloc_req;
	logic [delay_pkg::ADDR_WIDTH-1:0] alloc_size;
	logic [delay_pkg::DELAY_WIDTH-1:0] alloc_delay;
	logic invalid_alloc;
	logic write_req;
	logic [delay_pkg::HANDLE_WIDTH-1:0] write_handle;
	logic signed [delay_pkg::DATA_WIDTH-1:0] write_data;
	logic signed [delay_pkg::DATA_WIDTH-1:0] write_inc;
	logic write_ack;
	logic write_done;
	logic invalid_write;
	logic read_req;
	logic [delay_pkg::HANDLE_WIDTH-1:0] read_handle;
	logic signed [delay_pkg::DATA_WIDTH-1:0] read_data;
	logic read_valid;
	logic invalid_read;

	row_t rows [$];
	int errors;

	// Reference model of the channels and the shared memory.
	int m_count;
	int m_next;
	int m_base [delay_pkg::N_CHANNELS];
	int m_size [delay_pkg::N_CHANNELS];
	int m_pos [delay_pkg::N_CHANNELS];
	int m_delay [delay_pkg::N_CHANNELS];
	int m_gain [delay_pkg::N_CHANNELS];
	bit m_wrapped [delay_pkg::N_CHANNELS];
	logic [15:0] m_out [delay_pkg::N_CHANNELS];
	logic [15:0] m_mem [delay_pkg::MEM_DEPTH];

	delay_engine i_dut (
		.clk           (clk),
		.reset         (reset),
		.enable        (enable),
		.alloc_req     (alloc_req),
		.alloc_size    (alloc_size),
		.alloc_delay   (alloc_delay),
		.invalid_alloc (invalid_alloc),
		.write_req     (write_req),
		.write_handle  (write_handle),
		.write_data    (write_data),
		.write_inc     (write_inc),
		.write_ack     (write_ack),
		.write_done    (write_done),
		.invalid_write (invalid_write),
		.read_req      (read_req),
		.read_handle   (read_handle),
		.read_data     (read_data),
		.read_valid    (read_valid),
		.invalid_read  (invalid_read)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic add_row(input int op, input int handle, input int value,
			input int delta, input bit rnd, input bit bad);
		row_t r;
		r = '{op, handle, value, delta, rnd, bad};
		rows.push_back(r);
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic report_missing(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic model_alloc(input int size, input int dly);
		int h;
		int lim;
		h = m_count;
		lim = size * 256;
		m_base[h] = m_next;
		m_size[h] = size;
		m_delay[h] = (dly > lim) ? lim : dly;
		m_pos[h] = 0;
		m_wrapped[h] = 1'b0;
		m_gain[h] = 0;
		m_out[h] = 16'h0000;
		m_next += size;
		m_count++;
	endtask

	// Sample goes in first, then the tap is read with the delay from before the increment.
	task automatic model_write(input int h, input logic [15:0] sample, input int inc);
		int tap;
		int nd;
		int lim;
		lim = m_size[h] * 256;
		tap = (m_pos[h] + m_size[h] - (m_delay[h] >> 8)) % m_size[h];
		m_mem[m_base[h] + m_pos[h]] = sample;
		m_out[h] = m_mem[m_base[h] + tap];
		nd = m_delay[h] + inc;
		m_delay[h] = (nd < 0) ? 0 : ((nd > lim) ? lim : nd);
		if (m_wrapped[h] && m_gain[h] < 16384)
			m_gain[h] += 64;
		if (m_pos[h] == m_size[h] - 1) begin
			m_pos[h] = 0;
			m_wrapped[h] = 1'b1;
		end else begin
			m_pos[h]++;
		end
	endtask

	function automatic logic [15:0] expected_read(input int h);
		int prod;
		prod = $signed(m_out[h]) * m_gain[h];
		return 16'(prod >>> 14);
	endfunction

	task automatic do_alloc(input int size, input int dly, input bit bad);
		alloc_req = 1'b1;
		alloc_size = 8'(size);
		alloc_delay = 24'(dly);
		step();
		alloc_req = 1'b0;
		if (invalid_alloc !== bad)
			report_value("invalid_alloc", 32'(invalid_alloc), 32'(bad));
		if (!bad)
			model_alloc(size, dly);
	endtask

	task automatic send_write(input int h, input logic [15:0] sample, input int inc);
		write_req = 1'b1;
		write_handle = 2'(h);
		write_data = sample;
		write_inc = 16'(inc);
	endtask

	task automatic wait_write_response(output bit seen);
		int n;
		n = 0;
		do begin
			step();
			n++;
		end while (write_ack !== 1'b1 && invalid_write !== 1'b1 && n < WAIT_LIMIT);
		seen = (write_ack === 1'b1) || (invalid_write === 1'b1);
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		do begin
			step();
			n++;
		end while (write_done !== 1'b1 && n < WAIT_LIMIT);
		if (write_done !== 1'b1)
			report_missing("write_done never arrived");
	endtask

	task automatic do_write(input int h, input logic [15:0] sample, input int inc,
			input bit bad);
		bit seen;
		send_write(h, sample, inc);
		wait_write_response(seen);
		write_req = 1'b0;
		if (!seen) begin
			report_missing($sformatf("no response to a write on handle %0d", h));
		end else begin
			if (invalid_write !== bad)
				report_value("invalid_write", 32'(invalid_write), 32'(bad));
			if (write_ack !== !bad)
				report_value("write_ack", 32'(write_ack), 32'(!bad));
			if (!bad) begin
				wait_done();
				model_write(h, sample, inc);
			end
		end
	endtask

	// Second request is held from the cycle the first one is acknowledged.
	task automatic do_pair(input int h, input logic [15:0] first, input logic [15:0] second);
		bit seen;
		bit done_seen;
		int n;
		send_write(h, first, 0);
		wait_write_response(seen);
		if (!seen) begin
			write_req = 1'b0;
			report_missing("first write of the pair was never acknowledged");
		end else begin
			send_write(h, second, 0);
			done_seen = 1'b0;
			seen = 1'b0;
			n = 0;
			while (!seen && n < 2 * WAIT_LIMIT) begin
				step();
				n++;
				if (write_ack === 1'b1) begin
					seen = 1'b1;
					if (!done_seen)
						report_missing("second write acknowledged before the first finished");
				end
				if (write_done === 1'b1 && !done_seen) begin
					done_seen = 1'b1;
					model_write(h, first, 0);
				end
			end
			write_req = 1'b0;
			if (!seen) begin
				report_missing("second write of the pair was never acknowledged");
			end else begin
				wait_done();
				model_write(h, second, 0);
			end
		end
	endtask

	task automatic do_read(input int h, input bit bad);
		int n;
		logic [15:0] exp;
		read_req = 1'b1;
		read_handle = 2'(h);
		n = 0;
		do begin
			step();
			n++;
		end while (read_valid !== 1'b1 && invalid_read !== 1'b1 && n < WAIT_LIMIT);
		read_req = 1'b0;
		if (read_valid !== 1'b1 && invalid_read !== 1'b1) begin
			report_missing($sformatf("no response to a read on handle %0d", h));
		end else begin
			if (invalid_read !== bad)
				report_value("invalid_read", 32'(invalid_read), 32'(bad));
			if (!bad) begin
				exp = expected_read(h);
				if (read_data !== exp)
					report_value("read_data", {16'h0, read_data}, {16'h0, exp});
			end
		end
	endtask

	initial begin
		int unsigned discard;
		row_t r;
		logic [15:0] sample;

		discard = $urandom(32'h9c832dee);
		errors = 0;
		m_count = 0;
		m_next = 0;
		reset = 1'b1;
		enable = 1'b1;
		alloc_req = 1'b0;
		alloc_size = '0;
		alloc_delay = '0;
		write_req = 1'b0;
		write_handle = '0;
		write_data = '0;
		write_inc = '0;
		read_req = 1'b0;
		read_handle = '0;

		// Allocation and unallocated handles.
		add_row(OP_ALLOC, 0, 8, 'h380, 0, 0);
		add_row(OP_ALLOC, 0, 4, 0, 0, 0);
		add_row(OP_ALLOC, 0, 250, 0, 0, 1);
		add_row(OP_ALLOC, 0, 8, 0, 0, 0);
		add_row(OP_WRITE, 3, 'h1234, 0, 0, 1);
		add_row(OP_READ, 3, 0, 0, 0, 1);
		add_row(OP_ALLOC, 0, 235, 'h1000, 0, 0);
		add_row(OP_ALLOC, 0, 1, 0, 0, 1);
		add_row(OP_READ, 3, 0, 0, 0, 0);
		// Channel 0 taps 3 samples back.
		repeat (4)
			add_row(OP_WRITE, 0, 0, 0, 1, 0);
		add_row(OP_READ, 0, 0, 0, 0, 0);
		repeat (6)
			add_row(OP_WRITE, 0, 0, 0, 1, 0);
		add_row(OP_READ, 0, 0, 0, 0, 0);
		// Unity sample, so read_data shows the gain itself.
		repeat (2)
			add_row(OP_WRITE, 1, 'h4000, 0, 0, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		repeat (3)
			add_row(OP_WRITE, 1, 'h4000, 0, 0, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		add_row(OP_WRITE, 1, 'h4000, 0, 0, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		// Delay pushed past both limits.
		add_row(OP_WRITE, 1, 0, -32767, 1, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		add_row(OP_WRITE, 1, 0, 32767, 1, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		add_row(OP_WRITE, 1, 0, 32767, 1, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		add_row(OP_WRITE, 1, 0, -1, 1, 0);
		add_row(OP_WRITE, 1, 0, 0, 1, 0);
		add_row(OP_READ, 1, 0, 0, 0, 0);
		add_row(OP_PAIR, 0, 0, 0, 1, 0);
		add_row(OP_READ, 0, 0, 0, 0, 0);

		fork
			begin
				repeat (rows.size() * 20) @(posedge clk);
				$display("Timeout: run went past %0d cycles", rows.size() * 20);
				$display("SOME TESTS FAILED");
				$finish;
			end
		join_none

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		step();

		foreach (rows[i]) begin
			r = rows[i];
			sample = r.rnd ? 16'($urandom) : 16'(r.value);
			case (r.op)
				OP_ALLOC: do_alloc(r.value, r.delta, r.bad);
				OP_WRITE: do_write(r.handle, sample, r.delta, r.bad);
				OP_READ:  do_read(r.handle, r.bad);
				default:  do_pair(r.handle, 16'($urandom), 16'($urandom));
			endcase
			step();
		end

		$display("Rows applied: %0d, errors: %0d", rows.size(), errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
logic/delay_pkg.sv
logic/delay_channel.sv
logic/command_dispatch.sv
logic/sample_memory.sv
logic/gain_output.sv
logic/delay_engine.sv
testbench/tb_delay_engine.sv
